// ==== Makefile ====
TOP = tb_gba_mem

sim:
	verilator --binary --timing --assert --top-module $(TOP) -f gba_mem_mux.f
	./obj_dir/V$(TOP) > sim.log 2>&1; cat sim.log
	grep -q "TB PASSED" sim.log

clean:
	rm -rf obj_dir sim.log

.PHONY: sim clean

// ==== design/access_sequencer.sv ====
`timescale 1ns/100ps

module access_sequencer (
    input  logic                     clk,
    input  logic                     resetn,
    input  logic                     rom_en,
    input  gba_mem_pkg::gba_addr_t   rom_addr,
    input  logic                     ram_cen,
    input  logic                     ram_wen,
    input  gba_mem_pkg::gba_addr_t   ram_addr,
    input  gba_mem_pkg::word_t       ram_wdata,
    input  gba_mem_pkg::byte_en_t    ram_be,
    output logic                     cpu_en,
    output gba_mem_pkg::port_sel_t   sdram_port,
    output gba_mem_pkg::sdram_addr_t sdram_addr,
    output gba_mem_pkg::word_t       sdram_wdata,
    output gba_mem_pkg::byte_en_t    sdram_be,
    output logic                     sdram_rd,
    output logic                     sdram_wr,
    input  logic                     sdram_ready,
    bram_if.issuer                   bram,
    output gba_mem_pkg::mem_state_t  state,
    output logic                     double_req    // last cycle was a rom+ram pair
);
    import gba_mem_pkg::*;

    logic      rom_single, ram_single;
    logic      bram_first;                     // cycle 0 request goes to block ram
    logic      req1_last;                      // final cycle of request 1
    logic      ram_sd_rd, ram_sd_wr;
    byte_en_t  ram_sd_be;

    // request 2 block ram registers, replayed in REQ2_BRAM
    gba_addr_t buf_addr;
    word_t     buf_wdata;
    byte_en_t  buf_be;
    logic      buf_rd, buf_wr;
    port_sel_t buf_port;

    assign rom_single = is_single(rom_addr[27:24]);
    assign ram_single = is_single(ram_addr[27:24]);
    assign bram_first = (state == MAIN) && (rom_en ? rom_single : (ram_cen && ram_single));
    assign req1_last  = bram_first || (state == REQ1_WAIT && sdram_ready);

    // ram side sdram command, rom space is never written
    always_comb begin
        ram_sd_rd = !ram_wen || is_read_only(ram_addr[27:24]);
        ram_sd_wr = ram_wen && !is_read_only(ram_addr[27:24]);
        if (is_cart_ram(ram_addr[27:24]))
            ram_sd_be = byte_en_t'(4'b0001 << ram_addr[1:0]);   // 8-bit bus on the cart
        else
            ram_sd_be = ram_be;
    end

    //////////////////////////////////////////////////
    // block ram request, cycle 0 from the cpu ports
    //////////////////////////////////////////////////

    always_comb begin
        bram.addr  = buf_addr;
        bram.wdata = buf_wdata;
        bram.be    = buf_be;
        bram.rd    = 1'b0;
        bram.wr    = 1'b0;
        bram.port  = PORT_NONE;
        if (state == MAIN) begin
            if (rom_en) begin                  // rom wins, ram follows as request 2
                if (rom_single) begin
                    bram.addr = rom_addr;
                    bram.be   = 4'b1111;
                    bram.rd   = 1'b1;
                    bram.port = PORT_ROM;
                end
            end else if (ram_cen && ram_single) begin
                bram.addr  = ram_addr;
                bram.wdata = ram_wdata;
                bram.be    = ram_be;
                bram.rd    = !ram_wen;
                bram.wr    = ram_wen;
                bram.port  = PORT_RAM;
            end
        end else begin                         // only REQ2_BRAM has these set
            bram.rd   = buf_rd;
            bram.wr   = buf_wr;
            bram.port = buf_port;
        end
    end

    //////////////////////////////////////////////////
    // state machine and sdram starts
    //////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (!resetn) begin
            state      <= MAIN;
            sdram_rd   <= 1'b0;
            sdram_wr   <= 1'b0;
            sdram_port <= PORT_NONE;
            double_req <= 1'b0;
            buf_rd     <= 1'b0;
            buf_wr     <= 1'b0;
            buf_port   <= PORT_NONE;
        end else begin
            sdram_rd <= 1'b0;                  // start is a single pulse
            sdram_wr <= 1'b0;
            case (state)
                MAIN, REQ1_WAIT: begin
                    if (state == MAIN) begin
                        buf_rd   <= 1'b0;
                        buf_wr   <= 1'b0;
                        buf_port <= PORT_NONE;
                    end
                    if (req1_last) begin
                        state      <= MAIN;
                        double_req <= rom_en && ram_cen;
                        if (rom_en && ram_cen) begin
                            if (ram_single) begin      // ram half from block ram
                                state     <= REQ2_BRAM;
                                buf_addr  <= ram_addr;
                                buf_wdata <= ram_wdata;
                                buf_be    <= ram_be;
                                buf_rd    <= !ram_wen;
                                buf_wr    <= ram_wen;
                                buf_port  <= PORT_RAM;
                            end else begin             // ram half from sdram
                                state       <= REQ2_START;
                                sdram_rd    <= ram_sd_rd;
                                sdram_wr    <= ram_sd_wr;
                                sdram_addr  <= to_sdram(ram_addr);
                                sdram_wdata <= ram_wdata;
                                sdram_be    <= ram_sd_be;
                                sdram_port  <= PORT_RAM;
                            end
                        end
                    end
                    // first request is not block ram, start it on sdram
                    if (state == MAIN && !bram_first) begin
                        if (rom_en) begin
                            state      <= REQ1_START;
                            sdram_rd   <= 1'b1;
                            sdram_addr <= to_sdram(rom_addr);
                            sdram_be   <= 4'b1111;
                            sdram_port <= PORT_ROM;
                        end else if (ram_cen) begin
                            state       <= REQ1_START;
                            sdram_rd    <= ram_sd_rd;
                            sdram_wr    <= ram_sd_wr;
                            sdram_addr  <= to_sdram(ram_addr);
                            sdram_wdata <= ram_wdata;
                            sdram_be    <= ram_sd_be;
                            sdram_port  <= PORT_RAM;
                        end
                    end
                end
                REQ1_START: state <= REQ1_WAIT;
                REQ2_BRAM:  state <= MAIN;
                REQ2_START: state <= REQ2_WAIT;
                REQ2_WAIT:  if (sdram_ready) state <= MAIN;
                default:    state <= MAIN;
            endcase
        end
    end

    // cpu ready for the whole memory cycle
    always_comb begin
        case ({rom_en, ram_cen})
            2'b00:   cpu_en = 1'b1;                      // nothing pending
            2'b10:   cpu_en = (state == MAIN) ? rom_single : (state == REQ1_WAIT && sdram_ready);
            2'b01:   cpu_en = (state == MAIN) ? ram_single : (state == REQ1_WAIT && sdram_ready);
            default: cpu_en = state == REQ2_BRAM || (state == REQ2_WAIT && sdram_ready);
        endcase
    end

endmodule

// ==== design/bram_if.sv ====
`timescale 1ns/100ps

// one block ram request per cycle, answered in the next cycle
interface bram_if;
    import gba_mem_pkg::*;

    gba_addr_t addr;
    word_t     wdata;
    byte_en_t  be;
    logic      rd;
    logic      wr;
    port_sel_t port;     // PORT_NONE when idle
    word_t     rdata;    // result of last cycle's request

    modport issuer (
        output addr, wdata, be, rd, wr, port
    );

    modport memory (
        input  addr, wdata, be, rd, wr,
        output rdata
    );

    modport monitor (
        input  rd, port, rdata
    );

endinterface

// ==== design/gba_mem_pkg.sv ====
package gba_mem_pkg;

    //////////////////////////////////////////////////
    // types
    //////////////////////////////////////////////////

    typedef logic [27:0] gba_addr_t;    // byte address inside the gba map
    typedef logic [31:0] word_t;
    typedef logic [3:0]  byte_en_t;     // one bit per byte lane
    typedef logic [3:0]  region_t;      // addr[27:24]
    typedef logic [23:0] sdram_addr_t;  // word address, stands for byte bits 25:2

    // owner of a request
    typedef enum logic [1:0] {
        PORT_NONE = 2'd0,
        PORT_ROM  = 2'd1,
        PORT_RAM  = 2'd2
    } port_sel_t;

    typedef enum logic [2:0] {
        MAIN       = 3'd0,      // idle, or block ram request driven in cycle 0
        REQ1_START = 3'd1,      // sdram request 1, first cycle
        REQ1_WAIT  = 3'd2,      // sdram request 1, wait for ready
        REQ2_BRAM  = 3'd3,      // single cycle request 2
        REQ2_START = 3'd4,      // sdram request 2, first cycle
        REQ2_WAIT  = 3'd5       // sdram request 2, wait for ready
    } mem_state_t;

    //////////////////////////////////////////////////
    // memory map
    //////////////////////////////////////////////////

    localparam region_t REGION_IWRAM = 4'h3;
    localparam region_t REGION_EWRAM = 4'h2;
    localparam int      IWRAM_WORDS  = 8192;           // 32 KB
    localparam word_t   FILL_WORD    = 32'hdeadbeef;   // unmapped single cycle regions

    // sdram layout: 32 MB rom at 0, then 256 KB ewram, then 64 KB cart ram
    localparam logic [7:0]  SDRAM_EWRAM_BASE = 8'b1000_0000;
    localparam logic [9:0]  SDRAM_CART_BASE  = 10'b10_0000_0100;
    localparam sdram_addr_t SDRAM_UNMAPPED   = '1;

    // everything but ewram and the game pak space answers in one cycle
    function automatic logic is_single(region_t region);
        return !(region == REGION_EWRAM || region[3]);
    endfunction

    function automatic logic is_read_only(region_t region);
        return region >= 4'h8 && region <= 4'hC;     // game pak rom, all wait states
    endfunction

    function automatic logic is_cart_ram(region_t region);
        return region[3:1] == 3'b111;                 // E and F mirror each other
    endfunction

    function automatic sdram_addr_t to_sdram(gba_addr_t addr);
        case (addr[27:24])
            4'h8, 4'h9, 4'hA, 4'hB, 4'hC: return {1'b0, addr[24:2]};
            REGION_EWRAM:                 return {SDRAM_EWRAM_BASE, addr[17:2]};
            4'hE, 4'hF:                   return {SDRAM_CART_BASE, addr[15:2]};
            default:                      return SDRAM_UNMAPPED;
        endcase
    endfunction

endpackage

// ==== design/gba_mem_top.sv ====
`timescale 1ns/100ps

module gba_mem_top (
    input  logic                     clk,
    input  logic                     resetn,

    // cpu instruction port
    input  logic                     rom_en,
    input  gba_mem_pkg::gba_addr_t   rom_addr,
    output gba_mem_pkg::word_t       rom_data,

    // cpu data port
    input  logic                     ram_cen,
    input  logic                     ram_wen,
    input  gba_mem_pkg::gba_addr_t   ram_addr,
    input  gba_mem_pkg::word_t       ram_wdata,
    input  gba_mem_pkg::byte_en_t    ram_be,
    output gba_mem_pkg::word_t       ram_data,

    output logic                     cpu_en,      // data valid next cycle

    // sdram
    output gba_mem_pkg::port_sel_t   sdram_port,
    output gba_mem_pkg::sdram_addr_t sdram_addr,
    output gba_mem_pkg::word_t       sdram_wdata,
    output gba_mem_pkg::byte_en_t    sdram_be,
    output logic                     sdram_rd,
    output logic                     sdram_wr,
    input  logic                     sdram_ready,
    input  gba_mem_pkg::word_t       sdram_rdata_rom,
    input  gba_mem_pkg::word_t       sdram_rdata_ram
);
    import gba_mem_pkg::*;

    mem_state_t state;
    logic       double_req;

    bram_if bram_bus ();

    access_sequencer u_seq (
        .clk         (clk),
        .resetn      (resetn),
        .rom_en      (rom_en),
        .rom_addr    (rom_addr),
        .ram_cen     (ram_cen),
        .ram_wen     (ram_wen),
        .ram_addr    (ram_addr),
        .ram_wdata   (ram_wdata),
        .ram_be      (ram_be),
        .cpu_en      (cpu_en),
        .sdram_port  (sdram_port),
        .sdram_addr  (sdram_addr),
        .sdram_wdata (sdram_wdata),
        .sdram_be    (sdram_be),
        .sdram_rd    (sdram_rd),
        .sdram_wr    (sdram_wr),
        .sdram_ready (sdram_ready),
        .bram        (bram_bus),
        .state       (state),
        .double_req  (double_req)
    );

    iwram_bank u_iwram (
        .clk  (clk),
        .bram (bram_bus)
    );

    rdata_return u_rdata (
        .clk             (clk),
        .resetn          (resetn),
        .bram            (bram_bus),
        .state           (state),
        .double_req      (double_req),
        .rom_en          (rom_en),
        .ram_cen         (ram_cen),
        .sdram_rdata_rom (sdram_rdata_rom),
        .sdram_rdata_ram (sdram_rdata_ram),
        .rom_data        (rom_data),
        .ram_data        (ram_data)
    );

endmodule

// ==== design/iwram_bank.sv ====
`timescale 1ns/100ps

module iwram_bank (
    input  logic   clk,
    bram_if.memory bram
);
    import gba_mem_pkg::*;

    word_t   mem [IWRAM_WORDS];     // 32 KB iwram
    word_t   q;                     // raw array output
    region_t region_r;              // region of last cycle's request
    logic    sel;
    logic [12:0] word_addr;

    assign sel       = bram.addr[27:24] == REGION_IWRAM;
    assign word_addr = bram.addr[14:2];    // mirrored over the whole region

    //////////////////////////////////////////////////
    // single port array, byte lanes
    //////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (sel && bram.wr) begin
            for (int b = 0; b < 4; b++) begin
                if (bram.be[b])
                    mem[word_addr][8*b +: 8] <= bram.wdata[8*b +: 8];
            end
        end
        if (bram.rd)
            q <= mem[word_addr];       // old data on a collision
    end

    always_ff @(posedge clk) begin
        region_r <= bram.addr[27:24];
    end

    // other single cycle regions have no backing memory here
    assign bram.rdata = (region_r == REGION_IWRAM) ? q : FILL_WORD;

endmodule

// ==== design/rdata_return.sv ====
`timescale 1ns/100ps

module rdata_return (
    input  logic                    clk,
    input  logic                    resetn,
    bram_if.monitor                 bram,
    input  gba_mem_pkg::mem_state_t state,
    input  logic                    double_req,
    input  logic                    rom_en,
    input  logic                    ram_cen,
    input  gba_mem_pkg::word_t      sdram_rdata_rom,
    input  gba_mem_pkg::word_t      sdram_rdata_ram,
    output gba_mem_pkg::word_t      rom_data,
    output gba_mem_pkg::word_t      ram_data
);
    import gba_mem_pkg::*;

    port_sel_t port_r;                 // block ram request one cycle back
    logic      rd_r;
    logic      rom_en_r, ram_cen_r;
    word_t     rom_buf, ram_buf;       // values the cpu sees between cycles
    word_t     rom_new;                // rom half of a double request

    //////////////////////////////////////////////////
    // delayed request flags
    //////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (!resetn) begin
            port_r    <= PORT_NONE;
            rd_r      <= 1'b0;
            rom_en_r  <= 1'b0;
            ram_cen_r <= 1'b0;
            rom_buf   <= '0;
            ram_buf   <= '0;
        end else begin
            port_r    <= bram.port;
            rd_r      <= bram.rd;
            rom_en_r  <= rom_en;
            ram_cen_r <= ram_cen;
            if (state == MAIN) begin       // capture what was shown this cycle
                rom_buf <= rom_data;
                ram_buf <= ram_data;
            end
        end
    end

    // request 2 reuses the block ram and may clobber the rom word
    always_ff @(posedge clk) begin
        if (state == REQ2_BRAM || state == REQ2_START)
            rom_new <= (port_r != PORT_NONE) ? bram.rdata : sdram_rdata_rom;
    end

    // new data only in MAIN, right after a ready cycle
    always_comb begin
        rom_data = rom_buf;
        ram_data = ram_buf;
        if (state == MAIN) begin
            if (rom_en_r) begin
                if (double_req)
                    rom_data = rom_new;
                else if (rd_r && port_r == PORT_ROM)
                    rom_data = bram.rdata;
                else
                    rom_data = sdram_rdata_rom;
            end
            if (ram_cen_r)
                ram_data = (rd_r && port_r == PORT_RAM) ? bram.rdata : sdram_rdata_ram;
        end
    end

endmodule

// ==== gba_mem_mux.f ====
design/gba_mem_pkg.sv
design/bram_if.sv
design/access_sequencer.sv
design/iwram_bank.sv
design/rdata_return.sv
design/gba_mem_top.sv
verification/sdram_model.sv
verification/tb_gba_mem.sv

// ==== verification/sdram_model.sv ====
`timescale 1ns/100ps

module sdram_model (
    input  logic                     clk,
    input  logic                     resetn,
    input  gba_mem_pkg::port_sel_t   port,
    input  gba_mem_pkg::sdram_addr_t addr,       // stable until the next start
    input  gba_mem_pkg::word_t       wdata,
    input  gba_mem_pkg::byte_en_t    be,
    input  logic                     rd,
    input  logic                     wr,
    output logic                     ready,
    output gba_mem_pkg::word_t       rdata_rom,
    output gba_mem_pkg::word_t       rdata_ram,
    output gba_mem_pkg::sdram_addr_t last_addr,  // log of the last start
    output gba_mem_pkg::byte_en_t    last_be,
    output logic                     last_rd,
    output logic                     last_wr,
    output int                       wr_count
);
    import gba_mem_pkg::*;

    localparam int LATENCY = 3;         // start cycle to ready cycle

    word_t     store [sdram_addr_t];    // only words that were written
    port_sel_t port_q;
    logic      rd_q, busy;
    int        cnt;
    word_t     w;

    // untouched words read back a pattern of their full address
    function automatic word_t peek(sdram_addr_t a);
        if (store.exists(a))
            return store[a];
        return {a[7:0] ^ a[23:16], a};
    endfunction

    always @(posedge clk) begin
        if (!resetn) begin
            ready     <= 1'b0;
            busy      <= 1'b0;
            rdata_rom <= '0;
            rdata_ram <= '0;
            last_rd   <= 1'b0;
            last_wr   <= 1'b0;
            wr_count  <= 0;
        end else begin
            ready <= 1'b0;
            if (rd || wr) begin                 // start pulse
                busy      <= 1'b1;
                cnt       <= LATENCY - 1;
                port_q    <= port;
                rd_q      <= rd;
                last_addr <= addr;
                last_be   <= be;
                last_rd   <= rd;
                last_wr   <= wr;
                if (wr)
                    wr_count <= wr_count + 1;
            end else if (busy) begin
                if (cnt == 1) begin             // last cycle, data and ready together
                    busy  <= 1'b0;
                    ready <= 1'b1;
                    if (rd_q && port_q == PORT_ROM)
                        rdata_rom <= peek(addr);
                    else if (rd_q)
                        rdata_ram <= peek(addr);
                    else begin
                        w = peek(addr);
                        for (int b = 0; b < 4; b++) begin
                            if (be[b])
                                w[8*b +: 8] = wdata[8*b +: 8];
                        end
                        store[addr] = w;
                    end
                end else
                    cnt <= cnt - 1;
            end
        end
    end

endmodule

// ==== verification/tb_gba_mem.sv ====
`timescale 1ns/100ps

module tb_gba_mem;
    import gba_mem_pkg::*;

    localparam int LAT     = 3;     // sdram model, start to ready
    localparam int TIMEOUT = 50;    // cycles allowed per request

    logic        clk = 1'b0;
    logic        resetn;
    logic        rom_en, ram_cen, ram_wen, cpu_en;
    gba_addr_t   rom_addr, ram_addr;
    word_t       ram_wdata, rom_data, ram_data;
    byte_en_t    ram_be, sdram_be, last_be;
    port_sel_t   sdram_port;
    sdram_addr_t sdram_addr, last_addr;
    word_t       sdram_wdata, sdram_rdata_rom, sdram_rdata_ram;
    logic        sdram_rd, sdram_wr, sdram_ready, last_rd, last_wr;
    int          wr_count;
    int          seed   = 32'h630dc19b;
    int          errors = 0;
    int          checks = 0;
    int          tests  = 0;

    always #4 clk = ~clk;           // 8 ns period

    gba_mem_top UUT (.*);

    sdram_model u_sdram (
        .clk       (clk),
        .resetn    (resetn),
        .port      (sdram_port),
        .addr      (sdram_addr),
        .wdata     (sdram_wdata),
        .be        (sdram_be),
        .rd        (sdram_rd),
        .wr        (sdram_wr),
        .ready     (sdram_ready),
        .rdata_rom (sdram_rdata_rom),
        .rdata_ram (sdram_rdata_ram),
        .last_addr (last_addr),
        .last_be   (last_be),
        .last_rd   (last_rd),
        .last_wr   (last_wr),
        .wr_count  (wr_count)
    );

    //////////////////////////////////////////////////
    // helpers
    //////////////////////////////////////////////////

    task automatic check_word(input string what, input word_t got, input word_t exp);
        checks++;
        assert (got === exp) else begin
            $display("** Error: %0t ns, %s: got %h, expected %h", $time, what, got, exp);
            errors++;
        end
    endtask

    function automatic word_t merge_bytes(word_t old_w, word_t new_w, byte_en_t be);
        word_t w;
        w = old_w;
        for (int b = 0; b < 4; b++) begin
            if (be[b])
                w[8*b +: 8] = new_w[8*b +: 8];
        end
        return w;
    endfunction

    // hold the request from a falling edge until cpu_en, then drop it
    task automatic cpu_access(input logic rom, input gba_addr_t raddr, input logic ram,
                              input logic wen, input gba_addr_t daddr, input word_t wdata,
                              input byte_en_t be, output int cycles);
        word_t rom_seen, ram_seen;
        @(negedge clk);
        rom_en    = rom;
        rom_addr  = raddr;
        ram_cen   = ram;
        ram_wen   = wen;
        ram_addr  = daddr;
        ram_wdata = wdata;
        ram_be    = be;
        cycles    = 0;
        #1;
        rom_seen = rom_data;        // old results stay put until after cpu_en
        ram_seen = ram_data;
        while (!cpu_en && cycles < TIMEOUT) begin
            @(negedge clk);
            #1;
            cycles++;
            check_word("rom_data hold", rom_data, rom_seen);
            check_word("ram_data hold", ram_data, ram_seen);
        end
        if (!cpu_en) begin
            $display("timeout: cpu_en did not come within %0d cycles at %0t ns",
                     TIMEOUT, $time);
            errors++;
        end else begin
            @(negedge clk);
            rom_en  = 1'b0;
            ram_cen = 1'b0;
            ram_wen = 1'b0;
            #1;                     // results of this request now valid
        end
    endtask

    task automatic close_test(input string name, input int errors_before);
        tests++;
        $display("test %0d %s: %0d errors", tests, name, errors - errors_before);
    endtask

    //////////////////////////////////////////////////
    // test sequence
    //////////////////////////////////////////////////

    initial begin
        gba_addr_t a, r, iw_addr, ew_addr;
        word_t     w, iw_word, ew_word, rom_word;
        byte_en_t  be;
        int        cyc, mark, wr_before;

        rom_en    = 1'b0;
        rom_addr  = '0;
        ram_cen   = 1'b0;
        ram_wen   = 1'b0;
        ram_addr  = '0;
        ram_wdata = '0;
        ram_be    = '0;
        resetn    = 1'b0;
        repeat (5) @(negedge clk);
        resetn = 1'b1;

        // iwram, answered in the request cycle
        mark    = errors;
        iw_addr = {REGION_IWRAM, 9'd0, 13'($random(seed)), 2'b00};
        w       = $random(seed);
        cpu_access(1'b0, '0, 1'b1, 1'b1, iw_addr, w, 4'b1111, cyc);
        check_word("iwram write cycles", word_t'(cyc), 0);
        be      = (byte_en_t'($random(seed)) & 4'b0111) | 4'b0001;   // never a full word
        iw_word = $random(seed);
        cpu_access(1'b0, '0, 1'b1, 1'b1, iw_addr, iw_word, be, cyc);
        iw_word = merge_bytes(w, iw_word, be);
        cpu_access(1'b0, '0, 1'b1, 1'b0, iw_addr, '0, 4'b1111, cyc);
        check_word("iwram read cycles", word_t'(cyc), 0);
        check_word("iwram merged word", ram_data, iw_word);
        cpu_access(1'b0, '0, 1'b1, 1'b0, 28'h500_0040, '0, 4'b1111, cyc);   // palette space
        check_word("region 5 fill", ram_data, FILL_WORD);
        close_test("iwram", mark);

        // ewram through sdram
        mark    = errors;
        ew_addr = {REGION_EWRAM, 6'd0, 16'($random(seed)), 2'b00};
        ew_word = $random(seed);
        cpu_access(1'b0, '0, 1'b1, 1'b1, ew_addr, ew_word, 4'b1111, cyc);
        check_word("ewram write cycles", word_t'(cyc), LAT + 1);
        check_word("ewram sdram addr", word_t'(last_addr),
                   word_t'({SDRAM_EWRAM_BASE, ew_addr[17:2]}));
        check_word("ewram write strobe", word_t'(last_wr), 1);
        cpu_access(1'b0, '0, 1'b1, 1'b0, ew_addr, '0, 4'b1111, cyc);
        check_word("ewram read back", ram_data, ew_word);
        close_test("ewram", mark);

        // game pak rom, stores turn into loads
        mark      = errors;
        r         = {4'h8, 22'($random(seed)), 2'b00};
        wr_before = wr_count;
        cpu_access(1'b0, '0, 1'b1, 1'b1, r, $random(seed), 4'b1111, cyc);
        check_word("rom store strobes", word_t'({last_rd, last_wr}), 32'b10);
        check_word("rom store writes", word_t'(wr_count - wr_before), 0);
        check_word("rom store addr", word_t'(last_addr), word_t'({1'b0, r[24:2]}));
        check_word("rom store data", ram_data, u_sdram.peek({1'b0, r[24:2]}));
        r = {4'h9, 22'($random(seed)), 2'b00};            // upper half of the rom
        cpu_access(1'b1, r, 1'b0, 1'b0, '0, '0, 4'b0000, cyc);
        rom_word = u_sdram.peek({1'b0, r[24:2]});
        check_word("rom fetch cycles", word_t'(cyc), LAT + 1);
        check_word("rom fetch addr", word_t'(last_addr), word_t'({1'b0, r[24:2]}));
        check_word("rom fetch data", rom_data, rom_word);
        cpu_access(1'b0, '0, 1'b1, 1'b0, ew_addr, '0, 4'b1111, cyc);   // rom_data held meanwhile
        check_word("rom_data after ewram read", rom_data, rom_word);
        close_test("game pak rom", mark);

        // cartridge ram, 8-bit bus so one lane per store
        mark = errors;
        for (int k = 0; k < 4; k++) begin
            a = {4'hE, 8'd0, 14'($random(seed)), 2'(k)};
            cpu_access(1'b0, '0, 1'b1, 1'b1, a, $random(seed), 4'b1111, cyc);
            check_word("cart ram lane", word_t'(last_be), word_t'(4'b0001 << k));
            check_word("cart ram addr", word_t'(last_addr),
                       word_t'({SDRAM_CART_BASE, a[15:2]}));
            check_word("cart ram write strobe", word_t'(last_wr), 1);
        end
        close_test("cart ram", mark);

        // rom and ram together, one cpu_en at the end of request 2
        mark = errors;
        r    = {4'h8, 22'($random(seed)), 2'b00};
        cpu_access(1'b1, r, 1'b1, 1'b0, iw_addr, '0, 4'b1111, cyc);
        check_word("rom+iwram cycles", word_t'(cyc), LAT + 2);   // sdram, then one bram cycle
        check_word("rom+iwram rom_data", rom_data, u_sdram.peek({1'b0, r[24:2]}));
        check_word("rom+iwram ram_data", ram_data, iw_word);
        r    = {4'h8, 22'($random(seed)), 2'b00};
        cpu_access(1'b1, r, 1'b1, 1'b0, ew_addr, '0, 4'b1111, cyc);
        check_word("rom+ewram cycles", word_t'(cyc), 2 * (LAT + 1));
        check_word("rom+ewram rom_data", rom_data, u_sdram.peek({1'b0, r[24:2]}));
        check_word("rom+ewram ram_data", ram_data, ew_word);
        close_test("double request", mark);

        $display("%0d tests, %0d checks, %0d errors", tests, checks, errors);
        if (errors == 0) begin
            $display("TB PASSED");
        end else begin
            $display("TB FAILED");
        end
        $finish;
    end

endmodule
